// File: alu_lane.sv
`include "exec_macros.svh"

module alu_lane import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input thread_id_t issue_thread,
	input alu_op_t issue_op,
	input reg_addr_t issue_rd,
	input logic issue_rd_wen,
	input xlen_t issue_op1,
	input xlen_t issue_op2,
	input xlen_t issue_target,
	output logic res_valid,
	output thread_id_t res_thread,
	output logic res_wen,
	output reg_addr_t res_rd,
	output xlen_t res_data,
	output logic res_jump,
	output xlen_t res_target
);
	xlen_t alu_res;
	logic is_beq;
	logic wen;
	logic taken;

	always_comb begin
		case (issue_op)
			`ALU_ADD: alu_res = issue_op1 + issue_op2;
			`ALU_SUB: alu_res = issue_op1 - issue_op2;
			`ALU_AND: alu_res = issue_op1 & issue_op2;
			`ALU_OR: alu_res = issue_op1 | issue_op2;
			`ALU_XOR: alu_res = issue_op1 ^ issue_op2;
			`ALU_SLL: alu_res = issue_op1 << issue_op2[4:0];
			`ALU_SLT: alu_res = ($signed(issue_op1) < $signed(issue_op2)) ? xlen_t'(1) : '0;
			default: alu_res = '0; // beq writes nothing
		endcase
	end

	assign is_beq = issue_op == `ALU_BEQ;
	assign wen = issue_valid && !is_beq && issue_rd_wen && issue_rd != '0; // x0 never written
	assign taken = issue_valid && is_beq && issue_op1 == issue_op2;

	always_ff @(posedge clk) begin
		if (!rst) begin
			res_valid <= 1'b0;
			res_thread <= '0;
			res_wen <= 1'b0;
			res_rd <= '0;
			res_data <= '0;
			res_jump <= 1'b0;
			res_target <= '0;
		end else begin
			res_valid <= issue_valid;
			res_thread <= issue_thread;
			res_wen <= wen;
			res_rd <= issue_rd;
			res_data <= alu_res;
			res_jump <= taken;
			res_target <= issue_target;
		end
	end

endmodule

// File: exec_chk.sv
`include "exec_macros.svh"

module exec_chk import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input thread_id_t dispatch_threads[`NUM_ALUS-1:0],
	input logic wb_wen[`NUM_THREADS-1:0],
	input logic jump_en[`NUM_THREADS-1:0]
);
	for (genvar a = 0; a < `NUM_ALUS; a++) begin : g_lane_a
		for (genvar b = a + 1; b < `NUM_ALUS; b++) begin : g_lane_b
			a_distinct_dispatch: assert property (@(posedge clk) disable iff (!rst)
				dispatch_threads[a] == `THREAD_IDLE || dispatch_threads[a] != dispatch_threads[b])
				else $error("lanes %0d and %0d dispatch the same thread", a, b);
		end
	end

	for (genvar t = 0; t < `NUM_THREADS; t++) begin : g_thread
		a_wb_or_jump: assert property (@(posedge clk) disable iff (!rst)
			!(wb_wen[t] && jump_en[t]))
			else $error("thread %0d writes back and jumps in one cycle", t);
		// first cycle after reset stays quiet
		a_quiet_after_reset: assert property (@(posedge clk)
			$rose(rst) |=> !wb_wen[t] && !jump_en[t])
			else $error("thread %0d active right after reset", t);
	end

endmodule

bind exec_stage exec_chk u_chk (
	.clk(clk),
	.rst(rst),
	.dispatch_threads(dispatch_threads),
	.wb_wen(wb_wen),
	.jump_en(jump_en)
);

// File: exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

`define NUM_THREADS 4
`define NUM_ALUS 2
`define QUEUE_DEPTH 3 // entries per thread

`define XLEN 32
`define REG_ADDR_W 5
`define THREAD_ID_W 3
`define THREAD_IDLE 3'd4 // lane left empty this cycle

// operation codes from decode
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR 3'd3
`define ALU_XOR 3'd4
`define ALU_SLL 3'd5
`define ALU_SLT 3'd6
`define ALU_BEQ 3'd7

`endif

// File: exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

	// operands, results and branch targets
	typedef logic [`XLEN-1:0] xlen_t;

	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// thread index, wide enough for the idle code
	typedef logic [`THREAD_ID_W-1:0] thread_id_t;

	typedef logic [2:0] alu_op_t; // one of the ALU_* codes

endpackage

// File: exec_stage.sv
`include "exec_macros.svh"

module exec_stage import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid[`NUM_THREADS-1:0],
	input alu_op_t in_op[`NUM_THREADS-1:0],
	input reg_addr_t in_rs1[`NUM_THREADS-1:0],
	input reg_addr_t in_rs2[`NUM_THREADS-1:0],
	input reg_addr_t in_rd[`NUM_THREADS-1:0],
	input logic in_rd_wen[`NUM_THREADS-1:0],
	input xlen_t in_op1[`NUM_THREADS-1:0],
	input xlen_t in_op2[`NUM_THREADS-1:0],
	input xlen_t in_target[`NUM_THREADS-1:0],
	input thread_id_t dispatch_threads[`NUM_ALUS-1:0],
	output logic in_ready[`NUM_THREADS-1:0],
	output logic wb_wen[`NUM_THREADS-1:0],
	output reg_addr_t wb_rd[`NUM_THREADS-1:0],
	output xlen_t wb_data[`NUM_THREADS-1:0],
	output logic jump_en[`NUM_THREADS-1:0],
	output xlen_t jump_addr[`NUM_THREADS-1:0]
);
	logic head_valid[`NUM_THREADS-1:0];
	alu_op_t head_op[`NUM_THREADS-1:0];
	reg_addr_t head_rd[`NUM_THREADS-1:0];
	logic head_rd_wen[`NUM_THREADS-1:0];
	xlen_t head_op1[`NUM_THREADS-1:0];
	xlen_t head_op2[`NUM_THREADS-1:0];
	xlen_t head_target[`NUM_THREADS-1:0];
	logic pop[`NUM_THREADS-1:0];

	logic issue_valid[`NUM_ALUS-1:0];
	thread_id_t issue_thread[`NUM_ALUS-1:0];
	alu_op_t issue_op[`NUM_ALUS-1:0];
	reg_addr_t issue_rd[`NUM_ALUS-1:0];
	logic issue_rd_wen[`NUM_ALUS-1:0];
	xlen_t issue_op1[`NUM_ALUS-1:0];
	xlen_t issue_op2[`NUM_ALUS-1:0];
	xlen_t issue_target[`NUM_ALUS-1:0];

	logic res_valid[`NUM_ALUS-1:0];
	thread_id_t res_thread[`NUM_ALUS-1:0];
	logic res_wen[`NUM_ALUS-1:0];
	reg_addr_t res_rd[`NUM_ALUS-1:0];
	xlen_t res_data[`NUM_ALUS-1:0];
	logic res_jump[`NUM_ALUS-1:0];
	xlen_t res_target[`NUM_ALUS-1:0];

	for (genvar t = 0; t < `NUM_THREADS; t++) begin : g_queue
		thread_queue u_queue (
			.clk(clk),
			.rst(rst),
			.in_valid(in_valid[t]),
			.in_op(in_op[t]),
			.in_rs1(in_rs1[t]),
			.in_rs2(in_rs2[t]),
			.in_rd(in_rd[t]),
			.in_rd_wen(in_rd_wen[t]),
			.in_op1(in_op1[t]),
			.in_op2(in_op2[t]),
			.in_target(in_target[t]),
			.in_ready(in_ready[t]),
			.pop(pop[t]),
			.wb_wen(wb_wen[t]), // forwarding from own results
			.wb_rd(wb_rd[t]),
			.wb_data(wb_data[t]),
			.jump_en(jump_en[t]), // flush
			.head_valid(head_valid[t]),
			.head_op(head_op[t]),
			.head_rd(head_rd[t]),
			.head_rd_wen(head_rd_wen[t]),
			.head_op1(head_op1[t]),
			.head_op2(head_op2[t]),
			.head_target(head_target[t])
		);
	end

	issue_xbar u_xbar (
		.dispatch_threads(dispatch_threads),
		.head_valid(head_valid),
		.head_op(head_op),
		.head_rd(head_rd),
		.head_rd_wen(head_rd_wen),
		.head_op1(head_op1),
		.head_op2(head_op2),
		.head_target(head_target),
		.pop(pop),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_op(issue_op),
		.issue_rd(issue_rd),
		.issue_rd_wen(issue_rd_wen),
		.issue_op1(issue_op1),
		.issue_op2(issue_op2),
		.issue_target(issue_target)
	);

	for (genvar l = 0; l < `NUM_ALUS; l++) begin : g_lane
		alu_lane u_lane (
			.clk(clk),
			.rst(rst),
			.issue_valid(issue_valid[l]),
			.issue_thread(issue_thread[l]),
			.issue_op(issue_op[l]),
			.issue_rd(issue_rd[l]),
			.issue_rd_wen(issue_rd_wen[l]),
			.issue_op1(issue_op1[l]),
			.issue_op2(issue_op2[l]),
			.issue_target(issue_target[l]),
			.res_valid(res_valid[l]),
			.res_thread(res_thread[l]),
			.res_wen(res_wen[l]),
			.res_rd(res_rd[l]),
			.res_data(res_data[l]),
			.res_jump(res_jump[l]),
			.res_target(res_target[l])
		);
	end

	result_router u_router (
		.res_valid(res_valid),
		.res_thread(res_thread),
		.res_wen(res_wen),
		.res_rd(res_rd),
		.res_data(res_data),
		.res_jump(res_jump),
		.res_target(res_target),
		.wb_wen(wb_wen),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.jump_en(jump_en),
		.jump_addr(jump_addr)
	);

endmodule

// File: exec_tb.sv
`include "exec_macros.svh"

module exec_tb import exec_pkg::*; ();
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int RUN_CYCLES = 2000;
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

	typedef struct {
		alu_op_t op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic rd_wen;
		xlen_t op1;
		xlen_t op2;
		xlen_t target;
	} entry_t;

	logic clk;
	logic rst;
	logic in_valid[`NUM_THREADS-1:0];
	alu_op_t in_op[`NUM_THREADS-1:0];
	reg_addr_t in_rs1[`NUM_THREADS-1:0];
	reg_addr_t in_rs2[`NUM_THREADS-1:0];
	reg_addr_t in_rd[`NUM_THREADS-1:0];
	logic in_rd_wen[`NUM_THREADS-1:0];
	xlen_t in_op1[`NUM_THREADS-1:0];
	xlen_t in_op2[`NUM_THREADS-1:0];
	xlen_t in_target[`NUM_THREADS-1:0];
	thread_id_t dispatch_threads[`NUM_ALUS-1:0];
	logic in_ready[`NUM_THREADS-1:0];
	logic wb_wen[`NUM_THREADS-1:0];
	reg_addr_t wb_rd[`NUM_THREADS-1:0];
	xlen_t wb_data[`NUM_THREADS-1:0];
	logic jump_en[`NUM_THREADS-1:0];
	xlen_t jump_addr[`NUM_THREADS-1:0];

	entry_t mq[`NUM_THREADS][`QUEUE_DEPTH]; // model queues, head at 0
	int mcnt[`NUM_THREADS];
	logic exp_ready[`NUM_THREADS];
	logic exp_wb_wen[`NUM_THREADS];
	reg_addr_t exp_wb_rd[`NUM_THREADS];
	xlen_t exp_wb_data[`NUM_THREADS];
	logic exp_jump_en[`NUM_THREADS];
	xlen_t exp_jump_addr[`NUM_THREADS];
	int n_wb;
	int n_jump;

	exec_stage uut (.*);

	function automatic xlen_t alu_ref(alu_op_t op, xlen_t a, xlen_t b);
		case (op)
			`ALU_ADD: return a + b;
			`ALU_SUB: return a - b;
			`ALU_AND: return a & b;
			`ALU_OR: return a | b;
			`ALU_XOR: return a ^ b;
			`ALU_SLL: return a << b[4:0];
			`ALU_SLT: return (a[31] != b[31]) ? xlen_t'(a[31]) : xlen_t'(a < b); // sign decides first
			default: return '0;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_outputs(input string tag);
		for (int t = 0; t < `NUM_THREADS; t++) begin
			check_val($sformatf("%s t%0d in_ready", tag, t), exp_ready[t], in_ready[t]);
			check_val($sformatf("%s t%0d wb_wen", tag, t), exp_wb_wen[t], wb_wen[t]);
			check_val($sformatf("%s t%0d jump_en", tag, t), exp_jump_en[t], jump_en[t]);
			if (exp_wb_wen[t]) begin
				check_val($sformatf("%s t%0d wb_rd", tag, t), exp_wb_rd[t], wb_rd[t]);
				check_val($sformatf("%s t%0d wb_data", tag, t), exp_wb_data[t], wb_data[t]);
			end
			if (exp_jump_en[t])
				check_val($sformatf("%s t%0d jump_addr", tag, t), exp_jump_addr[t], jump_addr[t]);
		end
	endtask

	task automatic drive_random();
		for (int t = 0; t < `NUM_THREADS; t++) begin
			in_valid[t] = in_ready[t] && ($urandom_range(3) != 0);
			in_op[t] = alu_op_t'($urandom_range(7));
			in_rs1[t] = reg_addr_t'($urandom_range(3)); // few registers, lots of forwarding
			in_rs2[t] = reg_addr_t'($urandom_range(3));
			in_rd[t] = reg_addr_t'($urandom_range(3));
			in_rd_wen[t] = $urandom_range(3) != 0;
			in_op1[t] = $urandom();
			in_op2[t] = ($urandom_range(3) == 0) ? in_op1[t] : $urandom(); // equal for beq
			in_target[t] = $urandom();
		end
		for (int l = 0; l < `NUM_ALUS; l++) begin
			dispatch_threads[l] = thread_id_t'($urandom_range(`NUM_THREADS));
			for (int k = 0; k < l; k++)
				if (dispatch_threads[k] == dispatch_threads[l])
					dispatch_threads[l] = `THREAD_IDLE;
		end
	endtask

	// advance the model over the coming rising edge
	task automatic step_model();
		entry_t head;
		logic took;
		logic fwd;
		reg_addr_t fwd_rd;
		xlen_t fwd_data;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			fwd = exp_wb_wen[t] && exp_wb_rd[t] != '0;
			fwd_rd = exp_wb_rd[t];
			fwd_data = exp_wb_data[t];
			head = mq[t][0];
			took = 1'b0;
			for (int l = 0; l < `NUM_ALUS; l++)
				if (dispatch_threads[l] == thread_id_t'(t) && mcnt[t] > 0 && !exp_jump_en[t])
					took = 1'b1;
			if (exp_jump_en[t]) begin
				mcnt[t] = 0; // flush drops queue and this cycle's enqueue
			end else begin
				if (took) begin
					for (int i = 0; i < `QUEUE_DEPTH - 1; i++)
						mq[t][i] = mq[t][i+1];
					mcnt[t]--;
				end
				if (in_valid[t] && exp_ready[t]) begin
					mq[t][mcnt[t]] = '{in_op[t], in_rs1[t], in_rs2[t], in_rd[t], in_rd_wen[t],
						in_op1[t], in_op2[t], in_target[t]};
					mcnt[t]++;
				end
				for (int i = 0; i < mcnt[t]; i++) begin
					if (fwd && mq[t][i].rs1 == fwd_rd)
						mq[t][i].op1 = fwd_data;
					if (fwd && mq[t][i].rs2 == fwd_rd)
						mq[t][i].op2 = fwd_data;
				end
			end
			exp_ready[t] = mcnt[t] < `QUEUE_DEPTH;
			exp_wb_wen[t] = took && head.op != `ALU_BEQ && head.rd_wen && head.rd != '0;
			exp_wb_rd[t] = head.rd;
			exp_wb_data[t] = alu_ref(head.op, head.op1, head.op2);
			exp_jump_en[t] = took && head.op == `ALU_BEQ && head.op1 == head.op2;
			exp_jump_addr[t] = head.target;
			n_wb += int'(exp_wb_wen[t]);
			n_jump += int'(exp_jump_en[t]);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the run of %0d cycles completed", RUN_CYCLES);
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(84402));
		rst = 1'b0;
		n_wb = 0;
		n_jump = 0;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			in_valid[t] = 1'b0;
			in_op[t] = '0;
			in_rs1[t] = '0;
			in_rs2[t] = '0;
			in_rd[t] = '0;
			in_rd_wen[t] = 1'b0;
			in_op1[t] = '0;
			in_op2[t] = '0;
			in_target[t] = '0;
			mcnt[t] = 0;
			exp_ready[t] = 1'b0; // low in reset and the cycle after
			exp_wb_wen[t] = 1'b0;
			exp_wb_rd[t] = '0;
			exp_wb_data[t] = '0;
			exp_jump_en[t] = 1'b0;
			exp_jump_addr[t] = '0;
			for (int i = 0; i < `QUEUE_DEPTH; i++)
				mq[t][i] = '{'0, '0, '0, '0, 1'b0, '0, '0, '0};
		end
		for (int l = 0; l < `NUM_ALUS; l++)
			dispatch_threads[l] = `THREAD_IDLE;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_outputs("reset");
		end
		rst = 1'b1;
		for (int c = 0; c < RUN_CYCLES; c++) begin
			check_outputs($sformatf("cycle %0d", c));
			drive_random();
			step_model();
			@(negedge clk);
		end
		$display("%0d writebacks and %0d jumps checked", n_wb, n_jump);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: issue_xbar.sv
`include "exec_macros.svh"

module issue_xbar import exec_pkg::*; (
	input thread_id_t dispatch_threads[`NUM_ALUS-1:0],
	input logic head_valid[`NUM_THREADS-1:0],
	input alu_op_t head_op[`NUM_THREADS-1:0],
	input reg_addr_t head_rd[`NUM_THREADS-1:0],
	input logic head_rd_wen[`NUM_THREADS-1:0],
	input xlen_t head_op1[`NUM_THREADS-1:0],
	input xlen_t head_op2[`NUM_THREADS-1:0],
	input xlen_t head_target[`NUM_THREADS-1:0],
	output logic pop[`NUM_THREADS-1:0],
	output logic issue_valid[`NUM_ALUS-1:0],
	output thread_id_t issue_thread[`NUM_ALUS-1:0],
	output alu_op_t issue_op[`NUM_ALUS-1:0],
	output reg_addr_t issue_rd[`NUM_ALUS-1:0],
	output logic issue_rd_wen[`NUM_ALUS-1:0],
	output xlen_t issue_op1[`NUM_ALUS-1:0],
	output xlen_t issue_op2[`NUM_ALUS-1:0],
	output xlen_t issue_target[`NUM_ALUS-1:0]
);
	always_comb begin
		for (int t = 0; t < `NUM_THREADS; t++)
			pop[t] = 1'b0;
		for (int l = 0; l < `NUM_ALUS; l++) begin
			issue_valid[l] = 1'b0;
			issue_thread[l] = dispatch_threads[l];
			issue_op[l] = '0;
			issue_rd[l] = '0;
			issue_rd_wen[l] = 1'b0;
			issue_op1[l] = '0;
			issue_op2[l] = '0;
			issue_target[l] = '0;
			if (dispatch_threads[l] != `THREAD_IDLE) begin
				for (int t = 0; t < `NUM_THREADS; t++) begin
					if (dispatch_threads[l] == thread_id_t'(t)) begin
						issue_valid[l] = head_valid[t]; // empty queue leaves lane idle
						issue_op[l] = head_op[t];
						issue_rd[l] = head_rd[t];
						issue_rd_wen[l] = head_rd_wen[t];
						issue_op1[l] = head_op1[t];
						issue_op2[l] = head_op2[t];
						issue_target[l] = head_target[t];
						pop[t] = pop[t] || head_valid[t];
					end
				end
			end
		end
	end

endmodule

// File: result_router.sv
`include "exec_macros.svh"

module result_router import exec_pkg::*; (
	input logic res_valid[`NUM_ALUS-1:0],
	input thread_id_t res_thread[`NUM_ALUS-1:0],
	input logic res_wen[`NUM_ALUS-1:0],
	input reg_addr_t res_rd[`NUM_ALUS-1:0],
	input xlen_t res_data[`NUM_ALUS-1:0],
	input logic res_jump[`NUM_ALUS-1:0],
	input xlen_t res_target[`NUM_ALUS-1:0],
	output logic wb_wen[`NUM_THREADS-1:0],
	output reg_addr_t wb_rd[`NUM_THREADS-1:0],
	output xlen_t wb_data[`NUM_THREADS-1:0],
	output logic jump_en[`NUM_THREADS-1:0],
	output xlen_t jump_addr[`NUM_THREADS-1:0]
);
	always_comb begin
		for (int t = 0; t < `NUM_THREADS; t++) begin
			wb_wen[t] = 1'b0;
			wb_rd[t] = '0;
			wb_data[t] = '0;
			jump_en[t] = 1'b0;
			jump_addr[t] = '0;
		end
		// at most one lane per thread, dispatch keeps them distinct
		for (int l = 0; l < `NUM_ALUS; l++) begin
			if (res_valid[l]) begin
				for (int t = 0; t < `NUM_THREADS; t++) begin
					if (res_thread[l] == thread_id_t'(t)) begin
						wb_wen[t] = res_wen[l];
						wb_rd[t] = res_rd[l];
						wb_data[t] = res_data[l];
						jump_en[t] = res_jump[l];
						jump_addr[t] = res_target[l];
					end
				end
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the exec_stage testbench, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exec_tb -f verilog.f -o exec_tb \
	> sim.log 2>&1 && ./obj_dir/exec_tb >> sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: thread_queue.sv
`include "exec_macros.svh"

module thread_queue import exec_pkg::*; #(
	parameter int DEPTH = `QUEUE_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input alu_op_t in_op,
	input reg_addr_t in_rs1,
	input reg_addr_t in_rs2,
	input reg_addr_t in_rd,
	input logic in_rd_wen,
	input xlen_t in_op1,
	input xlen_t in_op2,
	input xlen_t in_target,
	output logic in_ready,
	input logic pop,
	input logic wb_wen,
	input reg_addr_t wb_rd,
	input xlen_t wb_data,
	input logic jump_en,
	output logic head_valid,
	output alu_op_t head_op,
	output reg_addr_t head_rd,
	output logic head_rd_wen,
	output xlen_t head_op1,
	output xlen_t head_op2,
	output xlen_t head_target
);
	localparam int CW = $clog2(DEPTH + 1);

	logic [CW-1:0] cnt;
	logic [CW-1:0] kept; // entries left after pop
	logic [CW-1:0] cnt_nxt;
	logic push;
	logic do_pop;
	logic fwd;

	alu_op_t q_op[DEPTH];
	reg_addr_t q_rs1[DEPTH];
	reg_addr_t q_rs2[DEPTH];
	reg_addr_t q_rd[DEPTH];
	logic q_rd_wen[DEPTH];
	xlen_t q_op1[DEPTH];
	xlen_t q_op2[DEPTH];
	xlen_t q_target[DEPTH];

	alu_op_t up_op[DEPTH];
	reg_addr_t up_rs1[DEPTH];
	reg_addr_t up_rs2[DEPTH];
	reg_addr_t up_rd[DEPTH];
	logic up_rd_wen[DEPTH];
	xlen_t up_op1[DEPTH];
	xlen_t up_op2[DEPTH];
	xlen_t up_target[DEPTH];

	alu_op_t n_op[DEPTH];
	reg_addr_t n_rs1[DEPTH];
	reg_addr_t n_rs2[DEPTH];
	reg_addr_t n_rd[DEPTH];
	logic n_rd_wen[DEPTH];
	xlen_t n_op1[DEPTH];
	xlen_t n_op2[DEPTH];
	xlen_t n_target[DEPTH];

	assign head_valid = cnt != '0 && !jump_en; // nothing leaves a flushing queue
	assign do_pop = pop && head_valid;
	assign push = in_valid && in_ready && !jump_en;
	assign fwd = wb_wen && wb_rd != '0;
	assign kept = cnt - CW'(do_pop);
	assign cnt_nxt = jump_en ? '0 : kept + CW'(push);

	// entry above each slot, seen after a pop
	for (genvar i = 0; i < DEPTH; i++) begin : g_up
		if (i < DEPTH - 1) begin : g_shift
			assign up_op[i] = q_op[i+1];
			assign up_rs1[i] = q_rs1[i+1];
			assign up_rs2[i] = q_rs2[i+1];
			assign up_rd[i] = q_rd[i+1];
			assign up_rd_wen[i] = q_rd_wen[i+1];
			assign up_op1[i] = q_op1[i+1];
			assign up_op2[i] = q_op2[i+1];
			assign up_target[i] = q_target[i+1];
		end else begin : g_top
			assign up_op[i] = '0;
			assign up_rs1[i] = '0;
			assign up_rs2[i] = '0;
			assign up_rd[i] = '0;
			assign up_rd_wen[i] = 1'b0;
			assign up_op1[i] = '0;
			assign up_op2[i] = '0;
			assign up_target[i] = '0;
		end
	end

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			n_op[i] = do_pop ? up_op[i] : q_op[i];
			n_rs1[i] = do_pop ? up_rs1[i] : q_rs1[i];
			n_rs2[i] = do_pop ? up_rs2[i] : q_rs2[i];
			n_rd[i] = do_pop ? up_rd[i] : q_rd[i];
			n_rd_wen[i] = do_pop ? up_rd_wen[i] : q_rd_wen[i];
			n_op1[i] = do_pop ? up_op1[i] : q_op1[i];
			n_op2[i] = do_pop ? up_op2[i] : q_op2[i];
			n_target[i] = do_pop ? up_target[i] : q_target[i];
			if (push && CW'(i) == kept) begin // new entry behind the survivors
				n_op[i] = in_op;
				n_rs1[i] = in_rs1;
				n_rs2[i] = in_rs2;
				n_rd[i] = in_rd;
				n_rd_wen[i] = in_rd_wen;
				n_op1[i] = in_op1;
				n_op2[i] = in_op2;
				n_target[i] = in_target;
			end
			if (fwd && n_rs1[i] == wb_rd)
				n_op1[i] = wb_data;
			if (fwd && n_rs2[i] == wb_rd)
				n_op2[i] = wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt <= '0;
			in_ready <= 1'b0;
		end else begin
			cnt <= cnt_nxt;
			in_ready <= cnt_nxt < CW'(DEPTH);
		end
	end

	always_ff @(posedge clk) begin
		q_op <= n_op;
		q_rs1 <= n_rs1;
		q_rs2 <= n_rs2;
		q_rd <= n_rd;
		q_rd_wen <= n_rd_wen;
		q_op1 <= n_op1;
		q_op2 <= n_op2;
		q_target <= n_target;
	end

	assign head_op = q_op[0];
	assign head_rd = q_rd[0];
	assign head_rd_wen = q_rd_wen[0];
	assign head_op1 = q_op1[0];
	assign head_op2 = q_op2[0];
	assign head_target = q_target[0];

endmodule

// File: verilog.f
+incdir+.
exec_pkg.sv
thread_queue.sv
issue_xbar.sv
alu_lane.sv
result_router.sv
exec_stage.sv
exec_chk.sv
exec_tb.sv
